//--- hw/cache_bus_top.sv
`timescale 1ns/1ns

module cache_bus_top (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             req_valid,
    input  logic                             req_uncached,
    input  logic                             req_dirty,
    input  logic [31:0]                      req_addr,
    input  logic [31:0]                      req_victim_addr,
    input  logic [2:0]                       req_size,
    input  logic [3:0]                       req_wstrb,
    input  logic [31:0]                      req_data,
    input  logic [mem_bus_pkg::line_bits-1:0] req_victim_line,
    output logic                             req_ready,
    output logic                             done,
    output logic [mem_bus_pkg::line_bits-1:0] refill_line,

    output logic [31:0]                      axi_awaddr,
    output logic [7:0]                       axi_awlen,
    output logic [1:0]                       axi_awburst,
    output logic [2:0]                       axi_awsize,
    output logic                             axi_awvalid,
    input  logic                             axi_awready,
    output logic [31:0]                      axi_wdata,
    output logic [3:0]                       axi_wstrb,
    output logic                             axi_wlast,
    output logic                             axi_wvalid,
    input  logic                             axi_wready,
    input  logic                             axi_bvalid,
    output logic                             axi_bready,

    output logic [31:0]                      axi_araddr,
    output logic [7:0]                       axi_arlen,
    output logic [1:0]                       axi_arburst,
    output logic [2:0]                       axi_arsize,
    output logic                             axi_arvalid,
    input  logic                             axi_arready,
    input  logic [31:0]                      axi_rdata,
    input  logic                             axi_rlast,
    input  logic                             axi_rvalid,
    output logic                             axi_rready
);

    logic                             wr_en;
    logic                             wr_uncached;
    logic [31:0]                      wr_addr;
    logic [2:0]                       wr_size;
    logic [3:0]                       wr_wstrb;
    logic [31:0]                      wr_data;
    logic [mem_bus_pkg::line_bits-1:0] wr_line;
    logic                             wr_empty;
    logic                             rd_en;
    logic [31:0]                      rd_addr;
    logic                             rd_empty;
    logic [mem_bus_pkg::line_bits-1:0] rd_line;

    miss_bus_ctrl u_ctrl (.*);

    write_axi_buffer u_wr_buf (
        .en         (wr_en),
        .uncached   (wr_uncached),
        .addr       (wr_addr),
        .size       (wr_size),
        .wstrb      (wr_wstrb),
        .data       (wr_data),
        .cache_line (wr_line),
        .empty      (wr_empty),
        .*
    );

    read_axi_buffer u_rd_buf (
        .en    (rd_en),
        .addr  (rd_addr),
        .empty (rd_empty),
        .line  (rd_line),
        .*
    );

endmodule

//--- hw/mem_bus_pkg.sv
package mem_bus_pkg;

    // Line geometry
    localparam int line_bytes = 16;
    localparam int line_words = line_bytes / 4;
    localparam int line_bits  = line_words * 32;

    // AXI burst encodings
    localparam logic [7:0] burst_len   = 8'(line_words - 1);
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [2:0] size_word   = 3'b010;

    // Write buffer FSM
    localparam logic [1:0] wr_idle = 2'd0;
    localparam logic [1:0] wr_addr = 2'd1;
    localparam logic [1:0] wr_data = 2'd2;
    localparam logic [1:0] wr_resp = 2'd3;

    // Read buffer FSM
    localparam logic [1:0] rd_idle = 2'd0;
    localparam logic [1:0] rd_addr = 2'd1;
    localparam logic [1:0] rd_data = 2'd2;

    // Byte address, or the same word split into line, word and byte
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [27:0] line_no;
            logic [1:0]  word;
            logic [1:0]  byte_off;
        } line;
    } bus_addr_u;

endpackage

//--- hw/miss_bus_ctrl.sv
`timescale 1ns/1ns

module miss_bus_ctrl (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             req_valid,
    input  logic                             req_uncached,
    input  logic                             req_dirty,
    input  logic [31:0]                      req_addr,
    input  logic [31:0]                      req_victim_addr,
    input  logic [2:0]                       req_size,
    input  logic [3:0]                       req_wstrb,
    input  logic [31:0]                      req_data,
    input  logic [mem_bus_pkg::line_bits-1:0] req_victim_line,
    output logic                             req_ready,
    output logic                             done,
    output logic [mem_bus_pkg::line_bits-1:0] refill_line,

    output logic                             wr_en,
    output logic                             wr_uncached,
    output logic [31:0]                      wr_addr,
    output logic [2:0]                       wr_size,
    output logic [3:0]                       wr_wstrb,
    output logic [31:0]                      wr_data,
    output logic [mem_bus_pkg::line_bits-1:0] wr_line,
    input  logic                             wr_empty,

    output logic                             rd_en,
    output logic [31:0]                      rd_addr,
    input  logic                             rd_empty,
    input  logic [mem_bus_pkg::line_bits-1:0] rd_line
);

    logic busy;
    logic wr_started;
    logic rd_started;
    logic accept;
    logic all_empty;

    // Only the buffers this request started are waited on
    assign all_empty = (!wr_started || wr_empty) && (!rd_started || rd_empty);
    assign done      = busy && all_empty;
    assign req_ready = !busy || all_empty;
    assign accept    = req_valid && req_ready;

    // Store or dirty victim goes out on the write side, every miss refills
    assign wr_en       = accept && (req_uncached || req_dirty);
    assign wr_uncached = req_uncached;
    assign wr_addr     = req_uncached ? req_addr : req_victim_addr;
    assign wr_size     = req_size;
    assign wr_wstrb    = req_wstrb;
    assign wr_data     = req_data;
    assign wr_line     = req_victim_line;

    assign rd_en   = accept && !req_uncached;
    assign rd_addr = req_addr;

    assign refill_line = rd_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            wr_started <= 1'b0;
            rd_started <= 1'b0;
        end else if (accept) begin
            busy       <= 1'b1;
            wr_started <= wr_en;
            rd_started <= rd_en;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

endmodule

//--- hw/read_axi_buffer.sv
`timescale 1ns/1ns

module read_axi_buffer (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             en,
    input  logic [31:0]                      addr,
    output logic                             empty,
    output logic [mem_bus_pkg::line_bits-1:0] line,

    output logic [31:0]                      axi_araddr,
    output logic [7:0]                       axi_arlen,
    output logic [1:0]                       axi_arburst,
    output logic [2:0]                       axi_arsize,
    output logic                             axi_arvalid,
    input  logic                             axi_arready,
    input  logic [31:0]                      axi_rdata,
    input  logic                             axi_rlast,
    input  logic                             axi_rvalid,
    output logic                             axi_rready
);

    logic [1:0]             state;
    logic [1:0]             state_next;
    logic                   accept;
    mem_bus_pkg::bus_addr_u line_addr;
    // Word field doubles as the beat counter
    mem_bus_pkg::bus_addr_u beat_addr;

    always_comb begin
        line_addr.raw = addr;
        line_addr.line.word = 2'd0;
        line_addr.line.byte_off = 2'd0;
    end

    assign accept = en && (state == mem_bus_pkg::rd_idle);
    assign empty  = state == mem_bus_pkg::rd_idle;

    assign axi_araddr  = (state == mem_bus_pkg::rd_idle) ? line_addr.raw : beat_addr.raw;
    assign axi_arlen   = mem_bus_pkg::burst_len;
    assign axi_arburst = mem_bus_pkg::burst_incr;
    assign axi_arsize  = mem_bus_pkg::size_word;
    assign axi_arvalid = accept || (state == mem_bus_pkg::rd_addr);
    assign axi_rready  = 1'b1;

    always_comb begin
        state_next = state;
        case (state)
            mem_bus_pkg::rd_idle: begin
                if (en) begin
                    state_next = axi_arready ? mem_bus_pkg::rd_data : mem_bus_pkg::rd_addr;
                end
            end
            mem_bus_pkg::rd_addr: begin
                if (axi_arready) begin
                    state_next = mem_bus_pkg::rd_data;
                end
            end
            default: begin
                if (axi_rvalid && axi_rlast) begin
                    state_next = mem_bus_pkg::rd_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::rd_idle;
        end else begin
            state <= state_next;
        end
    end

    // Line holds its last refill until the next burst overwrites it
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_addr <= line_addr;
        end else if ((state == mem_bus_pkg::rd_data) && axi_rvalid) begin
            line[beat_addr.line.word * 32 +: 32] <= axi_rdata;
            beat_addr.line.word <= beat_addr.line.word + 2'd1;
        end
    end

endmodule

//--- hw/write_axi_buffer.sv
`timescale 1ns/1ns

module write_axi_buffer (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             en,
    input  logic                             uncached,
    input  logic [31:0]                      addr,
    input  logic [2:0]                       size,
    input  logic [3:0]                       wstrb,
    input  logic [31:0]                      data,
    input  logic [mem_bus_pkg::line_bits-1:0] cache_line,
    output logic                             empty,

    output logic [31:0]                      axi_awaddr,
    output logic [7:0]                       axi_awlen,
    output logic [1:0]                       axi_awburst,
    output logic [2:0]                       axi_awsize,
    output logic                             axi_awvalid,
    input  logic                             axi_awready,
    output logic [31:0]                      axi_wdata,
    output logic [3:0]                       axi_wstrb,
    output logic                             axi_wlast,
    output logic                             axi_wvalid,
    input  logic                             axi_wready,
    input  logic                             axi_bvalid,
    output logic                             axi_bready
);

    logic [1:0]                       state;
    logic [1:0]                       state_next;
    logic [1:0]                       beat;
    logic                             last_beat;
    logic                             accept;
    logic                             aw_from_input;
    logic                             aw_uncached;
    mem_bus_pkg::bus_addr_u           line_addr;
    logic [31:0]                      start_addr;

    logic                             uncached_q;
    logic [31:0]                      addr_q;
    logic [2:0]                       size_q;
    logic [3:0]                       wstrb_q;
    logic [31:0]                      data_q;
    logic [mem_bus_pkg::line_bits-1:0] line_q;

    // Cached traffic starts at the line boundary
    always_comb begin
        line_addr.raw = addr;
        line_addr.line.word = 2'd0;
        line_addr.line.byte_off = 2'd0;
        start_addr = uncached ? addr : line_addr.raw;
    end

    assign accept = en && (state == mem_bus_pkg::wr_idle);
    assign empty  = state == mem_bus_pkg::wr_idle;

    // In idle the request is presented straight from the inputs
    assign aw_from_input = state == mem_bus_pkg::wr_idle;
    assign aw_uncached   = aw_from_input ? uncached : uncached_q;

    assign axi_awaddr  = aw_from_input ? start_addr : addr_q;
    assign axi_awlen   = aw_uncached ? 8'd0 : mem_bus_pkg::burst_len;
    assign axi_awburst = aw_uncached ? mem_bus_pkg::burst_fixed : mem_bus_pkg::burst_incr;
    assign axi_awsize  = aw_uncached ? (aw_from_input ? size : size_q) : mem_bus_pkg::size_word;
    assign axi_awvalid = accept || (state == mem_bus_pkg::wr_addr);

    assign last_beat  = uncached_q || (beat == 2'(mem_bus_pkg::line_words - 1));
    assign axi_wvalid = state == mem_bus_pkg::wr_data;
    assign axi_wdata  = uncached_q ? data_q : line_q[beat * 32 +: 32];
    assign axi_wstrb  = uncached_q ? wstrb_q : 4'hf;
    assign axi_wlast  = axi_wvalid && last_beat;
    assign axi_bready = 1'b1;

    always_comb begin
        state_next = state;
        case (state)
            mem_bus_pkg::wr_idle: begin
                if (en) begin
                    state_next = axi_awready ? mem_bus_pkg::wr_data : mem_bus_pkg::wr_addr;
                end
            end
            mem_bus_pkg::wr_addr: begin
                if (axi_awready) begin
                    state_next = mem_bus_pkg::wr_data;
                end
            end
            mem_bus_pkg::wr_data: begin
                if (axi_wready && last_beat) begin
                    state_next = mem_bus_pkg::wr_resp;
                end
            end
            mem_bus_pkg::wr_resp: begin
                if (axi_bvalid) begin
                    state_next = mem_bus_pkg::wr_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::wr_idle;
            beat  <= 2'd0;
        end else begin
            state <= state_next;
            if (accept) begin
                beat <= 2'd0;
            end else if (axi_wvalid && axi_wready) begin
                beat <= beat + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uncached_q <= uncached;
            addr_q     <= start_addr;
            size_q     <= size;
            wstrb_q    <= wstrb;
            data_q     <= data;
            line_q     <= cache_line;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the cache bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -f src.f --top-module cache_bus_tb -o cache_bus_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/cache_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

//--- src.f
hw/mem_bus_pkg.sv
hw/write_axi_buffer.sv
hw/read_axi_buffer.sv
hw/miss_bus_ctrl.sv
hw/cache_bus_top.sv
test/cache_bus_assertions.sv
test/cache_bus_tb.sv

//--- test/cache_bus_assertions.sv
`timescale 1ns/1ns

module cache_bus_assertions (
    input logic        clk,
    input logic        rst,
    input logic [31:0] axi_awaddr,
    input logic        axi_awvalid,
    input logic        axi_awready,
    input logic        axi_wvalid,
    input logic        axi_wready,
    input logic        axi_arvalid,
    input logic        axi_arready,
    input logic        req_ready,
    input logic        done
);

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_awvalid && !axi_awready) |=> (axi_awvalid && $stable(axi_awaddr)))
        else $error("awvalid or awaddr changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_wvalid && !axi_wready) |=> axi_wvalid)
        else $error("wvalid dropped before wready");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        (axi_arvalid && !axi_arready) |=> axi_arvalid)
        else $error("arvalid dropped before arready");

    // A request keeps req_ready low until the cycle of its done pulse
    done_ready: assert property (@(posedge clk) disable iff (rst)
        done |-> (req_ready && !$past(req_ready)))
        else $error("req_ready did not rise together with done");

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high on two cycles in a row");

endmodule

bind cache_bus_top cache_bus_assertions u_assertions (.*);

//--- test/cache_bus_patterns.txt
# op(0 store,1 clean miss,2 dirty miss) addr victim_addr size wstrb data, all hex
# dirty miss victim line word i is data + i
0 00000104 00000000 2 f 11223344
0 00000108 00000000 1 3 0000abcd
0 0000010e 00000000 0 4 00ee0000
1 00000100 00000000 2 f 00000000
2 00000208 00000104 2 f a0000000
1 0000010c 00000000 2 f 00000000
0 00000300 00000000 2 9 cafe00be
2 00000304 00000040 2 f 5a5a0000
1 00000044 00000000 2 f 00000000
0 00000048 00000000 2 c beef0000
2 00000380 00000040 2 f 12340000
1 00000040 00000000 2 f 00000000
0 000003fc 00000000 2 f 77665544
2 00000120 000003f0 2 f 0f0f0000
1 000003f4 00000000 2 f 00000000
2 00000000 00000200 2 f 99990000

//--- test/cache_bus_tb.sv
`timescale 1ns/1ns

module cache_bus_tb;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    logic         req_valid = 1'b0, req_uncached = 1'b0, req_dirty = 1'b0;
    logic [31:0]  req_addr = '0, req_victim_addr = '0, req_data = '0;
    logic [2:0]   req_size = '0;
    logic [3:0]   req_wstrb = '0;
    logic [127:0] req_victim_line = '0;
    logic         req_ready, done;
    logic [127:0] refill_line;
    logic [31:0]  axi_awaddr, axi_wdata, axi_araddr;
    logic [31:0]  axi_rdata = '0;
    logic [7:0]   axi_awlen, axi_arlen;
    logic [1:0]   axi_awburst, axi_arburst;
    logic [2:0]   axi_awsize, axi_arsize;
    logic [3:0]   axi_wstrb;
    logic         axi_awvalid, axi_wlast, axi_wvalid, axi_bready, axi_arvalid, axi_rready;
    logic         axi_awready = 1'b0, axi_wready = 1'b0, axi_bvalid = 1'b0;
    logic         axi_arready = 1'b0, axi_rlast = 1'b0, axi_rvalid = 1'b0;

    logic [31:0]  mem [256];
    logic [31:0]  ref_mem [256];
    logic [15:0]  lfsr = 16'd88;
    int           errors = 0, done_count = 0, cycles = 0, n_pat = 0, limit = 1000;
    logic [1:0]   p_op [64];
    logic [31:0]  p_addr [64], p_vaddr [64], p_data [64];
    logic [2:0]   p_size [64];
    logic [3:0]   p_strb [64];

    // Memory model bookkeeping, cleared before every request
    int           aw_count, w_count, ar_count, w_word, w_beat, r_word, r_beat;
    logic         r_active;
    logic [31:0]  last_awaddr, last_araddr;
    logic [7:0]   last_awlen, last_arlen;
    logic [2:0]   last_awsize, last_arsize;
    logic [1:0]   last_awburst, last_arburst;
    logic [3:0]   last_wstrb;

    cache_bus_top DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("** Error %s: got %0h expected %0h", name, actual, expected);
            errors++;
        end
    endtask

    // AXI slave with random stalls
    always @(posedge clk) begin
        logic b;
        take_bit(b);
        axi_awready <= b;
        take_bit(b);
        axi_wready <= b;
        take_bit(b);
        axi_arready <= b;
        if (axi_bvalid) begin
            check_value("axi_bready", axi_bready, 1);
        end
        if (axi_rvalid) begin
            check_value("axi_rready", axi_rready, 1);
        end
        axi_bvalid <= 1'b0;
        if (axi_awvalid && axi_awready) begin
            aw_count++;
            last_awaddr = axi_awaddr;
            last_awlen = axi_awlen;
            last_awsize = axi_awsize;
            last_awburst = axi_awburst;
            w_word = axi_awaddr[9:2];
            w_beat = 0;
        end
        if (axi_wvalid && axi_wready) begin
            check_value("axi_wlast", axi_wlast, w_beat == last_awlen);
            for (int i = 0; i < 4; i++) begin
                if (axi_wstrb[i]) begin
                    mem[(w_word + w_beat) % 256][i*8 +: 8] = axi_wdata[i*8 +: 8];
                end
            end
            last_wstrb = axi_wstrb;
            w_count++;
            w_beat++;
            if (axi_wlast) begin
                axi_bvalid <= 1'b1;
            end
        end
        if (axi_arvalid && axi_arready) begin
            ar_count++;
            last_araddr = axi_araddr;
            last_arlen = axi_arlen;
            last_arsize = axi_arsize;
            last_arburst = axi_arburst;
            r_active = 1'b1;
            r_word = axi_araddr[9:2];
            r_beat = 0;
        end else if (axi_rvalid) begin
            r_beat++;
            if (r_beat == 4) begin
                r_active = 1'b0;
            end
        end
        if (r_active) begin
            take_bit(b);
            axi_rvalid <= b;
            axi_rdata <= mem[(r_word + r_beat) % 256];
            axi_rlast <= r_beat == 3;
        end else begin
            axi_rvalid <= 1'b0;
            axi_rlast <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic run_request(input int k);
        logic [127:0] victim;
        logic [127:0] expected_line;
        int           wait_cycles;
        logic [31:0]  line_base;
        for (int i = 0; i < 4; i++) begin
            victim[i*32 +: 32] = p_data[k] + i;
        end
        aw_count = 0;
        w_count = 0;
        ar_count = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_uncached <= p_op[k] == 2'd0;
        req_dirty <= p_op[k] == 2'd2;
        req_addr <= p_addr[k];
        req_victim_addr <= p_vaddr[k];
        req_size <= p_size[k];
        req_wstrb <= p_strb[k];
        req_data <= p_data[k];
        req_victim_line <= victim;
        @(posedge clk);
        req_valid <= 1'b0;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!done && wait_cycles < 200);
        if (!done) begin
            $display("Request %0d got no done pulse", k);
            errors++;
        end
        // Reference memory follows the pattern rules only
        if (p_op[k] == 2'd0) begin
            for (int i = 0; i < 4; i++) begin
                if (p_strb[k][i]) begin
                    ref_mem[p_addr[k][9:2]][i*8 +: 8] = p_data[k][i*8 +: 8];
                end
            end
            check_value("axi_awaddr", last_awaddr, p_addr[k]);
            check_value("axi_awlen", last_awlen, 0);
            check_value("axi_awsize", last_awsize, p_size[k]);
            check_value("axi_wstrb", last_wstrb, p_strb[k]);
            check_value("aw count", aw_count, 1);
            check_value("w beats", w_count, 1);
            check_value("ar count", ar_count, 0);
        end else begin
            if (p_op[k] == 2'd2) begin
                line_base = p_vaddr[k] & 32'hffff_fff0;
                for (int i = 0; i < 4; i++) begin
                    ref_mem[line_base[9:2] + i] = victim[i*32 +: 32];
                end
                check_value("axi_awaddr", last_awaddr, line_base);
                check_value("axi_awlen", last_awlen, 3);
                check_value("axi_awsize", last_awsize, 3'd2);
                check_value("axi_awburst", last_awburst, 2'b01);
                check_value("axi_wstrb", last_wstrb, 4'hf);
                check_value("w beats", w_count, 4);
            end
            line_base = p_addr[k] & 32'hffff_fff0;
            for (int i = 0; i < 4; i++) begin
                expected_line[i*32 +: 32] = ref_mem[line_base[9:2] + i];
            end
            check_value("axi_araddr", last_araddr, line_base);
            check_value("axi_arlen", last_arlen, 3);
            check_value("axi_arsize", last_arsize, 3'd2);
            check_value("axi_arburst", last_arburst, 2'b01);
            check_value("ar count", ar_count, 1);
            check_value("aw count", aw_count, p_op[k] == 2'd2 ? 1 : 0);
            check_value("refill_line", refill_line, expected_line);
        end
    endtask

    initial begin
        int    fd;
        string text;
        int    op, size, strb;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i * 4) ^ 32'h3c5a_0000;
            ref_mem[i] = mem[i];
        end
        r_active = 1'b0;
        fd = $fopen("test/cache_bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            $display("Simulation FAILED");
            $finish;
        end else begin
            while (!$feof(fd) && n_pat < 64) begin
                if ($fgets(text, fd) > 0 && text.len() > 1 && text[0] != "#") begin
                    if ($sscanf(text, "%h %h %h %h %h %h", op, p_addr[n_pat],
                                p_vaddr[n_pat], size, strb, p_data[n_pat]) == 6) begin
                        p_op[n_pat] = 2'(op);
                        p_size[n_pat] = 3'(size);
                        p_strb[n_pat] = 4'(strb);
                        n_pat++;
                    end
                end
            end
            $fclose(fd);
            limit = n_pat * 64 + 100;
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            check_value("req_ready", req_ready, 1);
            check_value("done", done, 0);
            check_value("axi_awvalid", axi_awvalid, 0);
            check_value("axi_wvalid", axi_wvalid, 0);
            check_value("axi_arvalid", axi_arvalid, 0);
            for (int k = 0; k < n_pat; k++) begin
                run_request(k);
            end
            repeat (4) @(negedge clk);
            check_value("done count", done_count, n_pat);
            for (int i = 0; i < 256; i++) begin
                check_value($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
            end
            $display("Patterns %0d, done pulses %0d, errors %0d", n_pat, done_count, errors);
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule
